// ==== build.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/id_ex_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/cpu_top.sv
test/tb_checker.sv
test/tb_top.sv

// ==== logic/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_XLEN        32
`define CPU_REG_IDX_W   5
`define CPU_IMEM_DEPTH  256
`define CPU_IMEM_ADDR_W 8

// opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BEQ   6'h04
`define OP_BNE   6'h05

// funct, instr[5:0]
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

`endif

// ==== logic/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`CPU_IMEM_ADDR_W-1:0] imem_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

endpackage

// ==== logic/cpu_top.sv ====
module cpu_top import cpu_pkg::*; (
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  logic       run,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  word_t      dmem_rdata,
    output logic       dmem_we,
    output logic       dmem_re,
    output word_t      dmem_addr,
    output word_t      dmem_wdata
);

    logic     fd_valid;
    word_t    fd_pc;
    word_t    fd_instr;
    logic     stall;
    logic     redirect;
    word_t    redirect_pc;
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    word_t    rd_data_a;
    word_t    rd_data_b;
    logic     wb_we;
    reg_idx_t wb_idx;
    word_t    wb_data;

    id_ex_if id_ex ();

    fetch_stage fetch_i (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .run         (run),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fd_valid    (fd_valid),
        .fd_pc       (fd_pc),
        .fd_instr    (fd_instr)
    );

    decode_stage decode_i (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .run         (run),
        .fd_valid    (fd_valid),
        .fd_pc       (fd_pc),
        .fd_instr    (fd_instr),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .rd_idx_a    (rd_idx_a),
        .rd_idx_b    (rd_idx_b),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .id_ex       (id_ex.decode)
    );

    reg_file reg_file_i (
        .clk_cpu   (clk_cpu),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .wb_we     (wb_we),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    execute_stage execute_i (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .run        (run),
        .dmem_rdata (dmem_rdata),
        .id_ex      (id_ex.execute),
        .wb_we      (wb_we),
        .wb_idx     (wb_idx),
        .wb_data    (wb_data),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

endmodule

// ==== logic/decode_stage.sv ====
`include "cpu_params.svh"

module decode_stage import cpu_pkg::*; (
    input  logic     clk_cpu,
    input  logic     rst_n,
    input  logic     run,
    input  logic     fd_valid,
    input  word_t    fd_pc,
    input  word_t    fd_instr,
    input  word_t    rd_data_a,
    input  word_t    rd_data_b,
    output reg_idx_t rd_idx_a,
    output reg_idx_t rd_idx_b,
    output logic     stall,
    output logic     redirect,
    output word_t    redirect_pc,
    id_ex_if.decode  id_ex
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      imm_ext;
    alu_op_t    alu_op;
    reg_idx_t   dest;
    logic       use_rs;
    logic       use_rt;
    logic       use_imm;
    logic       wr_en;
    logic       ld_en;
    logic       st_en;
    logic       is_beq;
    logic       is_bne;
    logic       ex_hit;
    logic       mem_hit;
    logic       load_use;
    logic       branch_wait;
    logic       taken;
    logic       issue;
    // writer now in the memory stage, tracked one cycle behind id_ex
    logic       mem_wr_q;
    reg_idx_t   mem_dest_q;

    assign opcode  = fd_instr[31:26];
    assign rs      = fd_instr[25:21];
    assign rt      = fd_instr[20:16];
    assign rd      = fd_instr[15:11];
    assign funct   = fd_instr[5:0];
    assign imm_ext = {{16{fd_instr[15]}}, fd_instr[15:0]};

    assign rd_idx_a = rs;
    assign rd_idx_b = rt;

    always_comb begin
        alu_op  = ALU_ADD;
        dest    = rt;
        use_rs  = 1'b0;
        use_rt  = 1'b0;
        use_imm = 1'b0;
        wr_en   = 1'b0;
        ld_en   = 1'b0;
        st_en   = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                dest   = rd;
                use_rs = 1'b1;
                use_rt = 1'b1;
                wr_en  = 1'b1;
                case (funct)
                    `FN_ADD: alu_op = ALU_ADD;
                    `FN_SUB: alu_op = ALU_SUB;
                    `FN_AND: alu_op = ALU_AND;
                    `FN_OR:  alu_op = ALU_OR;
                    `FN_SLT: alu_op = ALU_SLT;
                    default: begin
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                        wr_en  = 1'b0;
                    end
                endcase
            end
            `OP_ADDI: begin
                use_rs  = 1'b1;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            `OP_LW: begin
                use_rs  = 1'b1;
                use_imm = 1'b1;
                wr_en   = 1'b1;
                ld_en   = 1'b1;
            end
            `OP_SW: begin
                use_rs  = 1'b1;
                use_rt  = 1'b1;
                use_imm = 1'b1;
                st_en   = 1'b1;
            end
            `OP_BEQ: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_beq = 1'b1;
            end
            `OP_BNE: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_bne = 1'b1;
            end
            default: ;
        endcase
    end

    // destination match against the execute and memory stage writers
    assign ex_hit = id_ex.valid && id_ex.reg_we &&
                    ((use_rs && id_ex.dest_idx == rs) || (use_rt && id_ex.dest_idx == rt));
    assign mem_hit = mem_wr_q &&
                     ((use_rs && mem_dest_q == rs) || (use_rt && mem_dest_q == rt));

    assign load_use    = ex_hit && id_ex.mem_re;
    // branches compare in decode, so wait until the operand reaches writeback
    assign branch_wait = (is_beq || is_bne) && (ex_hit || mem_hit);

    assign stall = fd_valid && (load_use || branch_wait);

    assign taken       = (is_beq && rd_data_a == rd_data_b) ||
                         (is_bne && rd_data_a != rd_data_b);
    assign redirect    = fd_valid && !stall && taken;
    assign redirect_pc = fd_pc + word_t'(4) + {imm_ext[29:0], 2'b00};

    assign issue = run && fd_valid && !stall;

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid  <= 1'b0;
            id_ex.reg_we <= 1'b0;
            id_ex.mem_re <= 1'b0;
            id_ex.mem_we <= 1'b0;
            mem_wr_q     <= 1'b0;
        end else begin
            id_ex.valid  <= issue;
            id_ex.reg_we <= issue && wr_en && dest != '0;
            id_ex.mem_re <= issue && ld_en;
            id_ex.mem_we <= issue && st_en;
            mem_wr_q     <= run && id_ex.valid && id_ex.reg_we;
        end
    end

    always_ff @(posedge clk_cpu) begin
        id_ex.alu_op     <= alu_op;
        id_ex.operand_a  <= rd_data_a;
        id_ex.operand_b  <= use_imm ? imm_ext : rd_data_b;
        id_ex.store_data <= rd_data_b;
        id_ex.rs_idx     <= use_rs ? rs : '0;
        id_ex.rt_idx     <= use_rt ? rt : '0;
        id_ex.dest_idx   <= dest;
        mem_dest_q       <= id_ex.dest_idx;
    end

endmodule

// ==== logic/execute_stage.sv ====
module execute_stage import cpu_pkg::*; (
    input  logic      clk_cpu,
    input  logic      rst_n,
    input  logic      run,
    input  word_t     dmem_rdata,
    id_ex_if.execute  id_ex,
    output logic      wb_we,
    output reg_idx_t  wb_idx,
    output word_t     wb_data,
    output logic      dmem_we,
    output logic      dmem_re,
    output word_t     dmem_addr,
    output word_t     dmem_wdata
);

    word_t    op_a;
    word_t    op_b;
    word_t    st_data;
    word_t    alu_out;
    // execute/memory register
    logic     em_reg_we;
    logic     em_mem_re;
    logic     em_mem_we;
    reg_idx_t em_dest;
    word_t    em_result;
    word_t    em_store;
    // memory/writeback register
    logic     mw_reg_we;
    logic     mw_mem_re;
    reg_idx_t mw_dest;
    word_t    mw_result;

    // memory stage result is younger, so it wins over writeback
    function automatic word_t fwd(input reg_idx_t idx, input word_t base,
                                  input logic m_we, input reg_idx_t m_idx, input word_t m_val,
                                  input logic w_we, input reg_idx_t w_idx, input word_t w_val);
        if (m_we && m_idx == idx && idx != '0) begin
            return m_val;
        end
        if (w_we && w_idx == idx && idx != '0) begin
            return w_val;
        end
        return base;
    endfunction

    always_comb begin
        op_a    = fwd(id_ex.rs_idx, id_ex.operand_a, em_reg_we, em_dest, em_result,
                      wb_we, wb_idx, wb_data);
        st_data = fwd(id_ex.rt_idx, id_ex.store_data, em_reg_we, em_dest, em_result,
                      wb_we, wb_idx, wb_data);
        // stores carry the offset in operand_b, rt only feeds store data
        if (id_ex.mem_we) begin
            op_b = id_ex.operand_b;
        end else begin
            op_b = fwd(id_ex.rt_idx, id_ex.operand_b, em_reg_we, em_dest, em_result,
                       wb_we, wb_idx, wb_data);
        end
    end

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLT: alu_out = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            em_reg_we <= 1'b0;
            em_mem_re <= 1'b0;
            em_mem_we <= 1'b0;
            mw_reg_we <= 1'b0;
            mw_mem_re <= 1'b0;
        end else begin
            em_reg_we <= run && id_ex.valid && id_ex.reg_we;
            em_mem_re <= run && id_ex.valid && id_ex.mem_re;
            em_mem_we <= run && id_ex.valid && id_ex.mem_we;
            mw_reg_we <= run && em_reg_we;
            mw_mem_re <= run && em_mem_re;
        end
    end

    always_ff @(posedge clk_cpu) begin
        em_dest   <= id_ex.dest_idx;
        em_result <= alu_out;
        em_store  <= st_data;
        mw_dest   <= em_dest;
        mw_result <= em_result;
    end

    assign dmem_we    = em_mem_we;
    assign dmem_re    = em_mem_re;
    assign dmem_addr  = em_result;
    assign dmem_wdata = em_store;

    // load data arrives one cycle after dmem_re
    assign wb_we   = mw_reg_we;
    assign wb_idx  = mw_dest;
    assign wb_data = mw_mem_re ? dmem_rdata : mw_result;

endmodule

// ==== logic/fetch_stage.sv ====
`include "cpu_params.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  logic       run,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  logic       stall,
    input  logic       redirect,
    input  word_t      redirect_pc,
    output logic       fd_valid,
    output word_t      fd_pc,
    output word_t      fd_instr
);

    word_t      imem [`CPU_IMEM_DEPTH];
    word_t      pc;
    imem_addr_t pc_word;
    logic       advance;

    assign pc_word = pc[`CPU_IMEM_ADDR_W+1:2];
    assign advance = run && !redirect && !stall;

    // program load port, only meaningful while run is low
    always_ff @(posedge clk_cpu) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else if (!run) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else if (redirect) begin
            // squash the slot fetched behind the branch
            pc       <= redirect_pc;
            fd_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + word_t'(4);
            fd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (advance) begin
            fd_pc    <= pc;
            fd_instr <= imem[pc_word];
        end
    end

endmodule

// ==== logic/id_ex_if.sv ====
interface id_ex_if import cpu_pkg::*; ();

    logic     valid;
    alu_op_t  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    word_t    store_data;
    // zero when the field is not a source
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t dest_idx;
    logic     reg_we;
    logic     mem_re;
    logic     mem_we;

    modport decode (
        output valid, alu_op, operand_a, operand_b, store_data,
        output rs_idx, rt_idx, dest_idx, reg_we, mem_re, mem_we
    );

    modport execute (
        input valid, alu_op, operand_a, operand_b, store_data,
        input rs_idx, rt_idx, dest_idx, reg_we, mem_re, mem_we
    );

endinterface

// ==== logic/reg_file.sv ====
`include "cpu_params.svh"

module reg_file import cpu_pkg::*; (
    input  logic     clk_cpu,
    input  logic     rst_n,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    input  logic     wb_we,
    input  reg_idx_t wb_idx,
    input  word_t    wb_data,
    output word_t    rd_data_a,
    output word_t    rd_data_b
);

    word_t regs [1 << `CPU_REG_IDX_W];

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `CPU_REG_IDX_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_idx != '0) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // write-before-read, r0 always reads zero
    assign rd_data_a = (rd_idx_a == '0) ? '0 :
                       (wb_we && wb_idx == rd_idx_a) ? wb_data : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 :
                       (wb_we && wb_idx == rd_idx_b) ? wb_data : regs[rd_idx_b];

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f build.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// ==== test/tb_checker.sv ====
`include "cpu_params.svh"

module tb_checker import cpu_pkg::*; (
    input logic  clk_cpu,
    input logic  rst_n,
    input logic  run,
    input logic  dmem_we,
    input logic  dmem_re,
    input word_t dmem_addr,
    input word_t dmem_wdata
);

    localparam int DMEM_WORDS = 1024;

    word_t exp_addr[$];
    word_t exp_data[$];
    int    mismatch_errs = 0;
    int    extra_errs = 0;
    int    missing_errs = 0;
    int    other_errs = 0;
    word_t want_addr;
    word_t want_data;
    logic  run_q = 1'b0;

    // instruction-set interpreter, queues the stores in program order
    function automatic int model_run(input word_t prog[`CPU_IMEM_DEPTH],
                                     input word_t mem_init[DMEM_WORDS]);
        word_t      regs[32];
        word_t      mem[DMEM_WORDS];
        word_t      pc;
        word_t      next_pc;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      addr;
        word_t      res;
        logic [5:0] op;
        logic       ok;
        logic       halted;
        int         steps;
        mem = mem_init;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        steps = 0;
        halted = 1'b0;
        while (!halted && steps < 4000) begin
            ins = prog[pc[9:2]];
            op = ins[31:26];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            next_pc = pc + 32'd4;
            steps++;
            case (op)
                `OP_RTYPE: begin
                    ok = 1'b1;
                    res = '0;
                    case (ins[5:0])
                        `FN_ADD: res = a + b;
                        `FN_SUB: res = a - b;
                        `FN_AND: res = a & b;
                        `FN_OR:  res = a | b;
                        `FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ok = 1'b0;
                    endcase
                    if (ok && ins[15:11] != 5'd0) begin
                        regs[ins[15:11]] = res;
                    end
                end
                `OP_ADDI: begin
                    if (ins[20:16] != 5'd0) begin
                        regs[ins[20:16]] = addr;
                    end
                end
                `OP_LW: begin
                    if (ins[20:16] != 5'd0) begin
                        regs[ins[20:16]] = mem[addr[11:2]];
                    end
                end
                `OP_SW: begin
                    mem[addr[11:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                `OP_BEQ, `OP_BNE: begin
                    if ((op == `OP_BEQ) == (a == b)) begin
                        next_pc = pc + 32'd4 + {imm[29:0], 2'b00};
                        // self-branch means halt
                        halted = (next_pc == pc);
                    end
                end
                default: ;
            endcase
            pc = next_pc;
        end
        if (!halted) begin
            $display("model never reached the halting branch within its step limit");
            other_errs++;
        end
        return steps;
    endfunction

    function automatic void report_missing();
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never appeared on the bus", exp_addr.size());
            missing_errs += exp_addr.size();
            exp_addr.delete();
            exp_data.delete();
        end
    endfunction

    always @(posedge clk_cpu) begin
        run_q <= run;
        if (!rst_n) begin
            if (dmem_we || dmem_re) begin
                $display("memory strobe active during reset at time %0t", $time);
                other_errs++;
            end
        end else if (!run && !run_q) begin
            // the memory stage drains for one cycle after run falls
            if (dmem_we || dmem_re) begin
                $display("memory strobe active while run is low at time %0t", $time);
                other_errs++;
            end
        end else if (dmem_we) begin
            if (exp_addr.size() == 0) begin
                $display("unexpected store at time %0t to address %h data %h",
                         $time, dmem_addr, dmem_wdata);
                extra_errs++;
            end else begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                if (dmem_addr !== want_addr) begin
                    $display("FAIL t=%0t dmem_addr expected %h actual %h",
                             $time, want_addr, dmem_addr);
                    mismatch_errs++;
                end
                if (dmem_wdata !== want_data) begin
                    $display("FAIL t=%0t dmem_wdata expected %h actual %h",
                             $time, want_data, dmem_wdata);
                    mismatch_errs++;
                end
            end
        end
    end

endmodule

// ==== test/tb_top.sv ====
`include "cpu_params.svh"

module tb_top import cpu_pkg::*; ();

    localparam int DMEM_WORDS = 1024;
    localparam int NUM_PROGS = 3;

    logic       clk_cpu;
    logic       rst_n;
    logic       run;
    logic       prog_we;
    imem_addr_t prog_addr;
    word_t      prog_data;
    word_t      dmem_rdata = '0;
    logic       dmem_we;
    logic       dmem_re;
    word_t      dmem_addr;
    word_t      dmem_wdata;

    word_t      dmem[DMEM_WORDS];
    logic       pend_re = 1'b0;
    logic [9:0] pend_idx = '0;
    word_t      prog[`CPU_IMEM_DEPTH];
    int         prog_len;
    int         n_steps;
    int         cycles;
    int         limit;
    int         total;
    logic       timed_out;

    initial begin
        clk_cpu = 1'b0;
        forever #2 clk_cpu = ~clk_cpu;
    end

    cpu_top dut_i (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .dmem_rdata (dmem_rdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

    tb_checker chk_i (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .run        (run),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

    // data memory, read data appears the cycle after dmem_re
    always @(posedge clk_cpu) begin
        if (dmem_we) begin
            dmem[dmem_addr[11:2]] <= dmem_wdata;
        end
        pend_re <= dmem_re;
        pend_idx <= dmem_addr[11:2];
    end

    always @(negedge clk_cpu) begin
        if (pend_re) begin
            dmem_rdata <= dmem[pend_idx];
        end
    end

    function automatic void emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    function automatic word_t enc_rtype(input reg_idx_t rd, input reg_idx_t rs,
                                        input reg_idx_t rt, input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_itype(input logic [5:0] op, input reg_idx_t rs,
                                        input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'(1 + $urandom % 7);
    endfunction

    function automatic logic [15:0] pick_offset();
        return 16'(($urandom % DMEM_WORDS) * 4);
    endfunction

    function automatic void emit_alu();
        logic [5:0] fns[5];
        fns = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT};
        if ($urandom % 4 == 0) begin
            emit(enc_itype(`OP_ADDI, pick_reg(), pick_reg(), 16'($urandom)));
        end else begin
            emit(enc_rtype(pick_reg(), pick_reg(), pick_reg(), fns[$urandom % 5]));
        end
    endfunction

    function automatic void gen_program();
        int          k;
        int          start;
        reg_idx_t    r;
        logic [15:0] off;
        for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
            prog[i] = '0;
        end
        prog_len = 0;
        for (int i = 1; i < 8; i++) begin
            emit(enc_itype(`OP_ADDI, 5'd0, reg_idx_t'(i), 16'($urandom)));
        end
        for (int i = 0; i < 30; i++) begin
            k = $urandom % 10;
            if (k < 5) begin
                emit_alu();
            end else if (k == 5) begin
                // load then immediate use
                r = pick_reg();
                emit(enc_itype(`OP_LW, 5'd0, r, pick_offset()));
                emit(enc_rtype(r, r, pick_reg(), `FN_ADD));
                emit(enc_itype(`OP_SW, 5'd0, r, pick_offset()));
            end else if (k < 8) begin
                emit(enc_itype(`OP_SW, 5'd0, pick_reg(), pick_offset()));
            end else begin
                k = 1 + $urandom % 3;
                emit(enc_itype(($urandom % 2 == 0) ? `OP_BEQ : `OP_BNE,
                               pick_reg(), pick_reg(), 16'(k)));
                repeat (k) emit_alu();
            end
        end
        // counted loop on r8
        emit(enc_itype(`OP_ADDI, 5'd0, 5'd8, 16'(2 + $urandom % 4)));
        start = prog_len;
        emit_alu();
        emit_alu();
        emit(enc_itype(`OP_SW, 5'd0, pick_reg(), pick_offset()));
        emit(enc_itype(`OP_ADDI, 5'd8, 5'd8, 16'hffff));
        off = 16'(start - (prog_len + 1));
        emit(enc_itype(`OP_BNE, 5'd8, 5'd0, off));
        for (int i = 1; i < 8; i++) begin
            emit(enc_itype(`OP_SW, 5'd0, reg_idx_t'(i), pick_offset()));
        end
        emit(enc_itype(`OP_BEQ, 5'd0, 5'd0, 16'hffff));
    endfunction

    initial begin
        void'($urandom(32'h2fda));
        rst_n = 1'b0;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        timed_out = 1'b0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = (i * 32'h9e3779b1) ^ 32'h0f1e2d3c;
        end
        repeat (10) @(posedge clk_cpu);
        @(negedge clk_cpu);
        rst_n = 1'b1;
        for (int p = 0; p < NUM_PROGS && !timed_out; p++) begin
            @(negedge clk_cpu);
            run = 1'b0;
            repeat (3) @(negedge clk_cpu);
            gen_program();
            n_steps = chk_i.model_run(prog, dmem);
            limit = 10 * n_steps + 200;
            for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
                @(negedge clk_cpu);
                prog_we = 1'b1;
                prog_addr = imem_addr_t'(i);
                prog_data = prog[i];
            end
            @(negedge clk_cpu);
            prog_we = 1'b0;
            run = 1'b1;
            cycles = 0;
            while (chk_i.exp_addr.size() != 0 && cycles < limit) begin
                @(negedge clk_cpu);
                cycles++;
            end
            if (chk_i.exp_addr.size() != 0) begin
                $display("timeout reached after %0d cycles in program %0d", cycles, p);
                chk_i.report_missing();
                timed_out = 1'b1;
            end else begin
                // catch stores after the last expected one
                repeat (20) @(posedge clk_cpu);
            end
        end
        @(negedge clk_cpu);
        run = 1'b0;
        repeat (5) @(posedge clk_cpu);
        total = chk_i.mismatch_errs + chk_i.extra_errs + chk_i.missing_errs +
                chk_i.other_errs;
        $display("errors: mismatch %0d extra %0d missing %0d other %0d",
                 chk_i.mismatch_errs, chk_i.extra_errs, chk_i.missing_errs,
                 chk_i.other_errs);
        if (total == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
